//--- compile.f
+incdir+src
+incdir+tests
src/rv_isa_pkg.sv
src/mem_stage_pkg.sv
src/mem_pipe_reg.sv
src/store_align.sv
src/data_ram.sv
src/writeback_select.sv
src/mem_stage.sv
tests/tb_mem_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the mem stage testbench with Verilator, runs it, and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_mem_stage \
    --Mdir obj_dir -o tb_mem_stage \
    && ./obj_dir/tb_mem_stage > sim.log 2>&1 \
    || { echo "build or simulation failed"; tail -n 20 sim.log 2>/dev/null; exit 1; }

grep -q "Simulation completed successfully" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; tail -n 20 sim.log; exit 1; }

//--- tests/tb_model.svh
// shadow data memory, expected-result model and compare tasks for the mem stage testbench
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

xlen_t       shadow [`RAM_WORDS];   // mirror of the data RAM
ex_mem_t     item_q [$];            // accepted items still in the stage
mem_wb_t     exp_bus_q [$];         // expected out_bus, same order
reg_write_t  exp_wr_q [$];          // expected register write, same order

// ************************************************************
// op classes
// ************************************************************
function automatic int access_bytes(mem_op_e op);
    case (op)
        op_lb, op_lbu, op_sb: return 1;
        op_lh, op_lhu, op_sh: return 2;
        op_lw, op_lwu, op_sw: return 4;
        op_ld, op_sd:         return 8;
        default:              return 0;   // no memory access
    endcase
endfunction

function automatic logic store_op(mem_op_e op);
    return op inside {op_sb, op_sh, op_sw, op_sd};
endfunction

function automatic logic load_op(mem_op_e op);
    return (access_bytes(op) != 0) && !store_op(op);
endfunction

// ************************************************************
// expected values
// ************************************************************
// bytes picked one at a time from the shadow dword, then extended
function automatic xlen_t load_value(mem_op_e op, xlen_t addr);
    xlen_t word;
    xlen_t v;
    int    n;
    int    lane;
    logic  sign;
    word = shadow[addr[3 +: $bits(ram_addr_t)]];
    lane = int'(addr[2:0]);
    n    = access_bytes(op);
    v    = '0;
    for (int b = 0; b < n; b++) begin
        v[b*8 +: 8] = word[(lane + b)*8 +: 8];
    end
    sign = !(op inside {op_lbu, op_lhu, op_lwu}) && v[n*8-1];   // unsigned loads fill zero
    for (int b = n; b < 8; b++) begin
        v[b*8 +: 8] = {8{sign}};
    end
    return v;
endfunction

function automatic reg_write_t expected_write(ex_mem_t it);
    reg_write_t w;
    w.rd    = it.inst[rd_hi:rd_lo];
    w.value = '0;
    w.wen   = 1'b1;
    if (it.op == op_alu) begin
        w.value = it.alu_out;
    end else if (it.op == op_link) begin
        w.value = it.pc + 64'd4;          // return address
    end else if (it.op == op_csr) begin
        w.value = it.src2;
    end else if (load_op(it.op)) begin
        w.value = load_value(it.op, it.alu_out);
    end else begin
        w.wen = 1'b0;                     // stores and op_none
    end
    if (w.rd == 5'd0) begin
        w.wen = 1'b0;                     // x0 never written
    end
    return w;
endfunction

// store lands in the shadow when it retires, with the writeback value of that cycle
task automatic apply_store(ex_mem_t it, wb_fwd_t f, output logic hit);
    xlen_t    data;
    reg_idx_t rs2;
    int       lane;
    rs2  = it.inst[rs2_hi:rs2_lo];
    hit  = f.valid && f.wen && (f.rd == rs2) && (rs2 != 5'd0);
    data = hit ? f.wdata : it.src2;
    lane = int'(it.alu_out[2:0]);
    for (int b = 0; b < access_bytes(it.op); b++) begin
        shadow[it.alu_out[3 +: $bits(ram_addr_t)]][(lane + b)*8 +: 8] = data[b*8 +: 8];
    end
endtask

// ************************************************************
// compare tasks
// ************************************************************
task automatic check_bus(string name, mem_wb_t got, mem_wb_t exp);
    if (got !== exp) begin
        fail_now($sformatf("ERR %0t %s got pc=%h inst=%h exp pc=%h inst=%h",
                           $time, name, got.pc, got.inst, exp.pc, exp.inst));
    end
endtask

// rd and value only matter when a write is expected
task automatic check_reg_write(string name, reg_write_t got, reg_write_t exp);
    if ((got.wen !== exp.wen) || (exp.wen && ({got.rd, got.value} !== {exp.rd, exp.value}))) begin
        fail_now($sformatf("ERR %0t %s got wen=%b rd=%0d value=%h exp wen=%b rd=%0d value=%h",
                           $time, name, got.wen, got.rd, got.value,
                           exp.wen, exp.rd, exp.value));
    end
endtask

task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
        fail_now($sformatf("ERR %0t %s got %b exp %b", $time, name, got, exp));
    end
endtask

`endif

//--- tests/tb_mem_stage.sv
// clock, reset, random traffic, watchdog and scoreboard for the memory-access stage
`timescale 1ns/1ns
`default_nettype none

module tb_mem_stage;

    import rv_isa_pkg::*;
    import mem_stage_pkg::*;

    `include "mem_stage_macros.svh"

    localparam int          CLK_NS      = 40;
    localparam int          N_ITEMS     = `RAM_WORDS + 1500;  // fill pass then random mix
    localparam longint      WATCHDOG_NS = 64'(CLK_NS) * 4 * N_ITEMS + 200 * CLK_NS;
    localparam int unsigned SEED        = 85783;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    ex_mem_t     in_bus;
    logic        out_valid;
    logic        out_ready;
    mem_wb_t     out_bus;
    reg_write_t  reg_wr;
    wb_fwd_t     wb_fwd;

    int          issued;
    int          retired;
    int          fwd_hits;      // stores that took the writeback value
    int          loads_seen;
    logic        pending;       // item on in_bus not taken yet
    logic        fresh_load;    // load captured on the last edge
    logic        was_stalled;   // valid output held by out_ready low
    mem_wb_t     held_bus;
    reg_write_t  held_wr;

    task automatic fail_now(string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    `include "tb_model.svh"

    mem_stage u_mem_stage (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_bus    (in_bus),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_bus   (out_bus),
        .reg_wr    (reg_wr),
        .wb_fwd    (wb_fwd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS/2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        fail_now("timeout, the DUT stopped retiring items");
    end

    // ************************************************************
    // stimulus
    // ************************************************************
    // sd to every dword with rs2 = x0 and a pattern spread over all address bits
    function automatic ex_mem_t fill_item(int idx);
        ex_mem_t it;
        xlen_t   addr;
        addr       = xlen_t'(idx) << 3;
        it.pc      = {$urandom, $urandom} & ~64'h3;
        it.inst    = $urandom;
        it.inst[rs2_hi:rs2_lo] = 5'd0;
        it.op      = op_sd;
        it.alu_out = addr;
        it.src2    = (addr * 64'h9e37_79b9_7f4a_7c15) ^ {addr[31:0], ~addr[31:0]};
        return it;
    endfunction

    function automatic ex_mem_t random_item();
        ex_mem_t     it;
        int unsigned pick;
        int unsigned idx;
        int unsigned lane;
        it.pc      = {$urandom, $urandom} & ~64'h3;
        it.inst    = $urandom;
        it.inst[rd_hi:rd_lo]   = reg_idx_t'($urandom_range(0, 7));  // x0 one time in eight
        it.inst[rs2_hi:rs2_lo] = reg_idx_t'($urandom_range(0, 7));
        it.alu_out = {$urandom, $urandom};
        it.src2    = {$urandom, $urandom};
        pick = $urandom_range(0, 99);
        if (pick < 8) it.op = op_none;
        else if (pick < 24) it.op = op_alu;
        else if (pick < 32) it.op = op_link;
        else if (pick < 40) it.op = op_csr;
        else if (pick < 72) it.op = mem_op_e'(int'(op_lb) + $urandom_range(0, 6));
        else it.op = mem_op_e'(int'(op_sb) + $urandom_range(0, 3));
        if (access_bytes(it.op) != 0) begin
            // mostly a small window so loads hit recent stores
            idx  = ($urandom_range(0, 3) == 0) ? $urandom_range(0, `RAM_WORDS - 1)
                                               : $urandom_range(0, 31);
            lane = $urandom_range(0, 7) & ~(access_bytes(it.op) - 1);  // size aligned
            it.alu_out = (xlen_t'(idx) << 3) | xlen_t'(lane);
        end
        return it;
    endfunction

    task automatic drive_cycle();
        if (!pending && issued < N_ITEMS &&
            (issued < `RAM_WORDS || $urandom_range(0, 99) < 85)) begin
            in_bus  = (issued < `RAM_WORDS) ? fill_item(issued) : random_item();
            pending = 1'b1;
            issued++;
        end
        in_valid     = pending;           // held until taken
        out_ready    = ($urandom_range(0, 99) < 80);
        wb_fwd.valid = ($urandom_range(0, 9) < 7);
        wb_fwd.wen   = ($urandom_range(0, 9) < 7);
        wb_fwd.rd    = reg_idx_t'($urandom_range(0, 7));
        wb_fwd.wdata = {$urandom, $urandom};
        // aim writeback at the rs2 of a waiting store half of the time
        if (item_q.size() != 0 && store_op(item_q[0].op) && $urandom_range(0, 1) == 1) begin
            wb_fwd.rd = item_q[0].inst[rs2_hi:rs2_lo];
        end
    endtask

    // ************************************************************
    // scoreboard sampled late in the cycle when outputs are settled
    // ************************************************************
    task automatic sample_cycle();
        logic       exp_out_valid;
        logic       exp_in_ready;
        logic       hit;
        ex_mem_t    it;
        mem_wb_t    bus;
        exp_out_valid = (item_q.size() != 0) && !fresh_load;  // load waits one cycle
        exp_in_ready  = out_ready && !fresh_load;
        check_bit("in_ready", in_ready, exp_in_ready);
        check_bit("out_valid", out_valid, exp_out_valid);
        if (exp_out_valid) begin
            check_bus("out_bus", out_bus, exp_bus_q[0]);
            check_reg_write("reg_wr", reg_wr, exp_wr_q[0]);
        end else begin
            check_bit("reg_wr.wen", reg_wr.wen, 1'b0);
        end
        if (was_stalled) begin
            check_bus("out_bus held", out_bus, held_bus);
            check_reg_write("reg_wr held", reg_wr, held_wr);
        end
        was_stalled = exp_out_valid && !out_ready;
        held_bus    = out_bus;
        held_wr     = reg_wr;
        fresh_load  = 1'b0;
        // retire first so a load taken on this edge sees the store leaving on it
        if (exp_out_valid && out_ready) begin
            it = item_q.pop_front();
            exp_bus_q.delete(0);
            exp_wr_q.delete(0);
            if (store_op(it.op)) begin
                apply_store(it, wb_fwd, hit);
                if (hit) fwd_hits++;
            end
            if (load_op(it.op)) loads_seen++;
            retired++;
        end
        if (in_valid && exp_in_ready) begin
            it       = in_bus;
            bus.pc   = it.pc;
            bus.inst = it.inst;
            item_q.push_back(it);
            exp_bus_q.push_back(bus);
            exp_wr_q.push_back(expected_write(it));
            fresh_load = load_op(it.op);
            pending    = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst = 1'b1;
        in_valid = 1'b0;
        in_bus = '0;
        out_ready = 1'b0;
        wb_fwd = '0;
        issued = 0;
        retired = 0;
        fwd_hits = 0;
        loads_seen = 0;
        pending = 1'b0;
        fresh_load = 1'b0;
        was_stalled = 1'b0;
        held_bus = '0;
        held_wr = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (retired < N_ITEMS) begin
            @(negedge clk);
            drive_cycle();
            #(CLK_NS/4);
            sample_cycle();
        end
        // stage must be empty once the model queue has drained
        @(negedge clk);
        in_valid  = 1'b0;
        out_ready = 1'b1;
        repeat (4) begin
            #(CLK_NS/4);
            check_bit("out_valid", out_valid, 1'b0);
            check_bit("reg_wr.wen", reg_wr.wen, 1'b0);
            @(negedge clk);
        end
        if (fwd_hits == 0 || loads_seen == 0) begin
            fail_now("random mix never exercised store forwarding or loads");
        end
        $display("items %0d, loads %0d, forwarded stores %0d", retired, loads_seen, fwd_hits);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/mem_stage.sv
// memory-access stage top, EX/MEM register, store path, data RAM and writeback select
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
    input  logic                       clk,
    input  logic                       rst,
    // from execute
    input  logic                       in_valid,
    output logic                       in_ready,
    input  mem_stage_pkg::ex_mem_t     in_bus,
    // to writeback
    output logic                       out_valid,
    input  logic                       out_ready,
    output mem_stage_pkg::mem_wb_t     out_bus,
    output mem_stage_pkg::reg_write_t  reg_wr,
    input  mem_stage_pkg::wb_fwd_t     wb_fwd
);

    import mem_stage_pkg::*;

    logic        stage_valid;
    ex_mem_t     stage;
    logic        leave;       // item retires this edge
    logic        st_en;
    ram_addr_t   st_addr;
    xlen_t       st_data;
    byte_mask_t  st_mask;
    xlen_t       ld_data;
    logic        ld_wait;

    // ************************************************************
    // EX/MEM register, advances with in_ready
    // ************************************************************
    mem_pipe_reg u_pipe_reg (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_bus      (in_bus),
        .advance     (in_ready),
        .stage_valid (stage_valid),
        .stage       (stage)
    );

    store_align u_store_align (
        .stage_valid (stage_valid),
        .stage       (stage),
        .wb_fwd      (wb_fwd),
        .leave       (leave),
        .st_en       (st_en),
        .st_addr     (st_addr),
        .st_data     (st_data),
        .st_mask     (st_mask)
    );

    data_ram u_data_ram (
        .clk         (clk),
        .rst         (rst),
        .stage_valid (stage_valid),
        .stage       (stage),
        .leave       (leave),
        .st_en       (st_en),
        .st_addr     (st_addr),
        .st_data     (st_data),
        .st_mask     (st_mask),
        .ld_data     (ld_data),
        .ld_wait     (ld_wait)
    );

    writeback_select u_wb_select (
        .stage_valid (stage_valid),
        .stage       (stage),
        .ld_data     (ld_data),
        .ld_wait     (ld_wait),
        .out_ready   (out_ready),
        .in_ready    (in_ready),
        .leave       (leave),
        .out_valid   (out_valid),
        .out_bus     (out_bus),
        .reg_wr      (reg_wr)
    );

endmodule

`default_nettype wire

//--- src/writeback_select.sv
// load lane extraction and extension, writeback value select, output handshake gating
`timescale 1ns/1ns
`default_nettype none

module writeback_select (
    input  logic                       stage_valid,
    input  mem_stage_pkg::ex_mem_t     stage,
    input  mem_stage_pkg::xlen_t       ld_data,
    input  logic                       ld_wait,
    input  logic                       out_ready,
    output logic                       in_ready,
    output logic                       leave,
    output logic                       out_valid,
    output mem_stage_pkg::mem_wb_t     out_bus,
    output mem_stage_pkg::reg_write_t  reg_wr
);

    import rv_isa_pkg::*;
    import mem_stage_pkg::*;

    `include "mem_stage_macros.svh"

    xlen_t     lane_data;   // addressed bytes moved to lane 0
    xlen_t     ld_ext;      // extended load result
    xlen_t     wdata;
    logic      wen_raw;     // op writes a register at all
    reg_idx_t  rd;

    assign rd        = stage.inst[rd_hi:rd_lo];
    assign lane_data = ld_data >> {stage.alu_out[$clog2(`BYTE_LANES)-1:0], 3'b000};

    // ************************************************************
    // load extension
    // ************************************************************
    always_comb begin
        case (stage.op)
            op_lb:   ld_ext = {{(`XLEN-8){lane_data[7]}}, lane_data[7:0]};
            op_lh:   ld_ext = {{(`XLEN-16){lane_data[15]}}, lane_data[15:0]};
            op_lw:   ld_ext = {{(`XLEN-32){lane_data[31]}}, lane_data[31:0]};
            op_ld:   ld_ext = lane_data;                 // whole dword, lane 0
            op_lbu:  ld_ext = {{(`XLEN-8){1'b0}}, lane_data[7:0]};
            op_lhu:  ld_ext = {{(`XLEN-16){1'b0}}, lane_data[15:0]};
            op_lwu:  ld_ext = {{(`XLEN-32){1'b0}}, lane_data[31:0]};
            default: ld_ext = '0;
        endcase
    end

    // ************************************************************
    // writeback value
    // ************************************************************
    always_comb begin
        wen_raw = 1'b1;
        case (stage.op)
            op_alu:  wdata = stage.alu_out;
            op_link: wdata = stage.pc + xlen_t'(4);     // return address
            op_csr:  wdata = stage.src2;                // old csr value
            default: begin
                wdata   = ld_ext;
                wen_raw = op_is_load(stage.op);         // stores, op_none write nothing
            end
        endcase
    end

    // ************************************************************
    // handshake, held back while the RAM read is in flight
    // ************************************************************
    assign out_valid = stage_valid && !ld_wait;
    assign leave     = out_valid && out_ready;
    assign in_ready  = out_ready && !ld_wait;

    assign out_bus.pc   = stage.pc;
    assign out_bus.inst = stage.inst;

    assign reg_wr.wen   = out_valid && wen_raw && (rd != '0);  // x0 stays zero
    assign reg_wr.rd    = rd;
    assign reg_wr.value = wdata;

endmodule

`default_nettype wire

//--- src/data_ram.sv
// dword-wide data RAM with byte-masked writes, registered read and load-wait FSM
`timescale 1ns/1ns
`default_nettype none

module data_ram (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stage_valid,
    input  mem_stage_pkg::ex_mem_t     stage,
    input  logic                       leave,
    input  logic                       st_en,
    input  mem_stage_pkg::ram_addr_t   st_addr,
    input  mem_stage_pkg::xlen_t       st_data,
    input  mem_stage_pkg::byte_mask_t  st_mask,
    output mem_stage_pkg::xlen_t       ld_data,
    output logic                       ld_wait
);

    import rv_isa_pkg::*;
    import mem_stage_pkg::*;

    `include "mem_stage_macros.svh"

    typedef enum logic [1:0] {
        ld_idle,    // no load in flight
        ld_read,    // read issued, data next edge
        ld_done     // data valid, wait for the load to leave
    } ld_state_e;

    xlen_t      mem [`RAM_WORDS];
    xlen_t      rd_q;           // read output register
    ram_addr_t  rd_addr;
    ld_state_e  ld_state_q;
    ld_state_e  ld_state;       // current state incl. a freshly captured load
    ld_state_e  ld_next;
    logic       load_here;

    assign load_here = stage_valid && op_is_load(stage.op);
    assign rd_addr   = stage.alu_out[$clog2(`BYTE_LANES) +: $bits(ram_addr_t)];

    // ************************************************************
    // load-wait FSM
    // ************************************************************
    // a load captured into an idle stage reads in its first cycle
    always_comb begin
        ld_state = ld_state_q;
        if (ld_state_q == ld_idle && load_here) begin
            ld_state = ld_read;
        end
    end

    always_comb begin
        ld_next = ld_state;
        case (ld_state)
            ld_read: ld_next = ld_done;                     // single cycle, no retry
            ld_done: ld_next = leave ? ld_idle : ld_done;   // hold under back-pressure
            default: ld_next = ld_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ld_state_q <= ld_idle;
        end else begin
            ld_state_q <= ld_next;
        end
    end

    assign ld_wait = (ld_state == ld_read);

    // ************************************************************
    // storage
    // ************************************************************
    always_ff @(posedge clk) begin
        if (st_en) begin
            for (int b = 0; b < `BYTE_LANES; b++) begin
                if (st_mask[b]) begin
                    mem[st_addr][b*8 +: 8] <= st_data[b*8 +: 8];
                end
            end
        end
    end

    // output register only moves when a new read is issued
    always_ff @(posedge clk) begin
        if (ld_state == ld_read) begin
            rd_q <= mem[rd_addr];
        end
    end

    assign ld_data = rd_q;

    // a store retiring while a load reads would mean two items in the stage
    a_no_rw_clash : assert property (
        @(posedge clk) disable iff (rst)
        !(st_en && ld_state == ld_read)
    ) else $error("store write during load read");

endmodule

`default_nettype wire

//--- src/store_align.sv
// store data forwarding from writeback, byte lane placement and byte mask
`timescale 1ns/1ns
`default_nettype none

module store_align (
    input  logic                       stage_valid,
    input  mem_stage_pkg::ex_mem_t     stage,
    input  mem_stage_pkg::wb_fwd_t     wb_fwd,
    input  logic                       leave,     // item leaves on this edge
    output logic                       st_en,
    output mem_stage_pkg::ram_addr_t   st_addr,
    output mem_stage_pkg::xlen_t       st_data,
    output mem_stage_pkg::byte_mask_t  st_mask
);

    import rv_isa_pkg::*;
    import mem_stage_pkg::*;

    `include "mem_stage_macros.svh"

    reg_idx_t                        rs2;
    logic                            fwd_hit;
    xlen_t                           src;         // store data after forwarding
    logic [$clog2(`BYTE_LANES)-1:0]  lane;        // byte offset in dword
    xlen_t                           data_sized;  // data at lane 0
    byte_mask_t                      mask_sized;  // mask at lane 0
    logic                            aligned;
    logic                            is_store;

    assign is_store = op_is_store(stage.op);
    assign rs2      = stage.inst[rs2_hi:rs2_lo];
    assign lane     = stage.alu_out[$clog2(`BYTE_LANES)-1:0];

    // ************************************************************
    // forwarding
    // ************************************************************
    // writeback retires the producer of rs2 in this cycle, x0 never forwards
    assign fwd_hit = wb_fwd.valid && wb_fwd.wen && (wb_fwd.rd == rs2) && (rs2 != '0);
    assign src     = fwd_hit ? wb_fwd.wdata : stage.src2;

    // ************************************************************
    // size decode and lane placement
    // ************************************************************
    always_comb begin
        data_sized = '0;
        mask_sized = '0;
        aligned    = 1'b1;
        case (stage.op)
            op_sb: begin
                data_sized = {{(`XLEN-8){1'b0}}, src[7:0]};
                mask_sized = 8'h01;
            end
            op_sh: begin
                data_sized = {{(`XLEN-16){1'b0}}, src[15:0]};
                mask_sized = 8'h03;
                aligned    = (lane[0] == 1'b0);
            end
            op_sw: begin
                data_sized = {{(`XLEN-32){1'b0}}, src[31:0]};
                mask_sized = 8'h0f;
                aligned    = (lane[1:0] == 2'b00);
            end
            op_sd: begin
                data_sized = src;
                mask_sized = 8'hff;
                aligned    = (lane == '0);
            end
            default: ;  // not a store, nothing to place
        endcase
    end

    assign st_data = data_sized << {lane, 3'b000};  // lane * 8 bits
    assign st_mask = mask_sized << lane;
    assign st_addr = stage.alu_out[$clog2(`BYTE_LANES) +: $bits(ram_addr_t)];

    // write only on the edge the store retires, so it never repeats under stall
    assign st_en = stage_valid && is_store && leave;

    // execute must never hand over a misaligned store
    always_comb begin
        if (stage_valid && is_store) begin
            a_store_aligned : assert (aligned)
                else $error("misaligned store, op %s addr %h", stage.op.name(), stage.alu_out);
        end
    end

endmodule

`default_nettype wire

//--- src/mem_pipe_reg.sv
// EX/MEM pipeline register, holds its contents while the stage is stalled
`timescale 1ns/1ns
`default_nettype none

module mem_pipe_reg (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  mem_stage_pkg::ex_mem_t  in_bus,
    input  logic                    advance,     // in_ready of the stage
    output logic                    stage_valid,
    output mem_stage_pkg::ex_mem_t  stage
);

    // ************************************************************
    // valid bit
    // ************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else if (advance) begin
            stage_valid <= in_valid;  // bubble in when execute has nothing
        end
    end

    // ************************************************************
    // payload
    // ************************************************************
    always_ff @(posedge clk) begin
        if (advance) begin
            stage <= in_bus;
        end
        // else hold for load wait or back-pressure
    end

    // a held item must reach writeback unchanged
    a_hold_stable : assert property (
        @(posedge clk) disable iff (rst)
        (stage_valid && !advance) |=> $stable(stage)
    ) else $error("EX/MEM payload changed while stalled");

endmodule

`default_nettype wire

//--- src/mem_stage_pkg.sv
// data-path vector types and the packed bundles passed between pipeline stages
`default_nettype none

package mem_stage_pkg;

    `include "mem_stage_macros.svh"

    typedef logic [`XLEN-1:0] xlen_t;                   // data word or byte address
    typedef logic [`BYTE_LANES-1:0] byte_mask_t;        // one strobe per byte lane
    typedef logic [$clog2(`RAM_WORDS)-1:0] ram_addr_t;  // dword index, addr[10:3]

    // ************************************************************
    // stage bundles
    // ************************************************************

    // from execute into the EX/MEM register
    typedef struct packed {
        xlen_t                pc;
        rv_isa_pkg::inst_t    inst;
        rv_isa_pkg::mem_op_e  op;
        xlen_t                alu_out;  // address for loads and stores
        xlen_t                src2;     // store data, or csr value
    } ex_mem_t;

    // passed on to writeback
    typedef struct packed {
        xlen_t              pc;
        rv_isa_pkg::inst_t  inst;
    } mem_wb_t;

    // register file write port
    typedef struct packed {
        logic                  wen;
        rv_isa_pkg::reg_idx_t  rd;
        xlen_t                 value;
    } reg_write_t;

    // what the writeback register is about to retire
    typedef struct packed {
        logic                  valid;
        logic                  wen;
        rv_isa_pkg::reg_idx_t  rd;
        xlen_t                 wdata;
    } wb_fwd_t;

endpackage

`default_nettype wire

//--- src/rv_isa_pkg.sv
// instruction field positions, register index type, memory-stage op enum and op classes
`default_nettype none

package rv_isa_pkg;

    `include "mem_stage_macros.svh"

    typedef logic [4:0] reg_idx_t;              // x0..x31
    typedef logic [`INST_W-1:0] inst_t;

    // rd and rs2 fields of the 32-bit encoding
    localparam int rd_lo  = 7;
    localparam int rd_hi  = 11;
    localparam int rs2_lo = 20;
    localparam int rs2_hi = 24;

    // operation as decoded by execute
    typedef enum logic [3:0] {
        op_none,
        op_alu,     // result in alu_out
        op_link,    // jal / jalr, writes pc+4
        op_csr,     // csr read value rides in src2
        op_lb,
        op_lh,
        op_lw,
        op_ld,
        op_lbu,
        op_lhu,
        op_lwu,
        op_sb,
        op_sh,
        op_sw,
        op_sd
    } mem_op_e;

    function automatic logic op_is_load(mem_op_e op);
        return op inside {op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu};
    endfunction

    function automatic logic op_is_store(mem_op_e op);
        return op inside {op_sb, op_sh, op_sw, op_sd};
    endfunction

endpackage

`default_nettype wire

//--- src/mem_stage_macros.svh
// data-path widths and data RAM depth for the memory-access stage
`ifndef MEM_STAGE_MACROS_SVH
`define MEM_STAGE_MACROS_SVH

// ************************************************************
// data path
// ************************************************************
`define XLEN 64         // data and address width
`define INST_W 32       // instruction word

// ************************************************************
// data RAM
// ************************************************************
// depth in dwords, indexed by address bits above the lane offset
`define RAM_WORDS 256
`define BYTE_LANES 8    // bytes per dword

`endif
